//--- sim.f
logic/cpuPkg.sv
logic/aluUnit.sv
logic/regFile.sv
logic/accessTimer.sv
logic/wordMemory.sv
logic/cpuControl.sv
logic/cpuDatapath.sv
logic/cpuTop.sv
dv/cpuTop_chk.sv
dv/cpuTb.sv

//--- Makefile
# Verilator flow for the multi-cycle core testbench

VERILATOR ?= verilator
TOP       ?= cpuTb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_TEXT ?= All tests passed

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/cpuTb.sv
`timescale 1ns/100ps
module cpuTb;

        localparam int memLatency  = 3;
        localparam int progLen     = 19;
        localparam int expLen      = 16;
        localparam int resetCycles = 10;
        localparam int gapAlu      = memLatency + 4;      // ALU, branch and jump
        localparam int gapLw       = 2 * memLatency + 5;
        localparam int gapSw       = 2 * memLatency + 4;
        localparam int cycleLimit  = progLen + resetCycles + expLen * gapLw + 50;

        logic        Load;
        logic        rst;
        logic        progWrite;
        logic [31:0] progAddr;
        logic [31:0] progData;
        logic        retire;
        logic [31:0] retirePc;
        logic        wbValid;
        logic [4:0]  wbReg;
        logic [31:0] wbData;
        logic        storeValid;
        logic [31:0] storeAddr;
        logic [31:0] storeData;

        logic [31:0] progMem [progLen];
        logic [31:0] expPc [expLen];
        logic        expWb [expLen];
        logic [4:0]  expReg [expLen];
        logic [31:0] expData [expLen];
        logic        expStore [expLen];
        logic [31:0] expAddr [expLen];
        logic [31:0] expStData [expLen];
        int          expGap [expLen];

        int cycleCount   = 0;
        int rowCount     = 0;
        int lastRetire   = 0;
        int mismatches   = 0;
        int resetStrobes = 0;

        cpuTop #(.memLatency (memLatency)) cpuTop_inst (
                .Load (Load), .rst (rst),
                .progWrite (progWrite), .progAddr (progAddr), .progData (progData),
                .retire (retire), .retirePc (retirePc),
                .wbValid (wbValid), .wbReg (wbReg), .wbData (wbData),
                .storeValid (storeValid), .storeAddr (storeAddr), .storeData (storeData)
        );

        bind cpuTop cpuTopChk cpuTopChk_inst (
                .Load (Load), .rst (rst), .memStart (memStart), .memDone (memDone),
                .retire (retire), .storeValid (storeValid)
        );

        initial begin
                Load = 1'b0;
                forever #5 Load = ~Load;
        end

        always @(posedge Load) begin
                cycleCount <= cycleCount + 1;
        end

        function automatic logic [31:0] encodeI(logic [5:0] op, int rs, int rt, int imm);
                return {op, rs[4:0], rt[4:0], imm[15:0]};
        endfunction

        function automatic logic [31:0] encodeR(int rs, int rt, int rd, logic [5:0] fn);
                return {cpuPkg::opRType, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
        endfunction

        function automatic logic [31:0] encodeJ(int target);
                return {cpuPkg::opJ, target[27:2]};  // Target in the same 256 MB region
        endfunction

        task automatic buildProgram();
                progMem[0]  = encodeI(cpuPkg::opAddiu, 0, 0, 7);        // Write to $zero
                progMem[1]  = encodeI(cpuPkg::opAddiu, 0, 1, 32'h0F0F);
                progMem[2]  = encodeI(cpuPkg::opAddiu, 0, 2, -32767);   // 0xFFFF8001
                progMem[3]  = encodeR(1, 2, 3, cpuPkg::fnAddu);
                progMem[4]  = encodeR(1, 2, 4, cpuPkg::fnSubu);
                progMem[5]  = encodeR(1, 2, 5, cpuPkg::fnAnd);
                progMem[6]  = encodeR(1, 2, 6, cpuPkg::fnOr);
                progMem[7]  = encodeR(2, 1, 7, cpuPkg::fnSlt);          // Negative rs
                progMem[8]  = encodeI(cpuPkg::opAddiu, 0, 9, 32'h00A0);
                progMem[9]  = encodeI(cpuPkg::opSw, 9, 4, -16);
                progMem[10] = encodeI(cpuPkg::opLw, 9, 8, -16);
                progMem[11] = encodeI(cpuPkg::opBeq, 1, 2, 5);          // Not taken
                progMem[12] = encodeI(cpuPkg::opBeq, 8, 4, 1);          // Taken, skips 0x34
                progMem[13] = encodeI(cpuPkg::opAddiu, 0, 10, 32'h0BAD);
                progMem[14] = encodeJ(32'h44);
                progMem[15] = encodeI(cpuPkg::opAddiu, 0, 10, 32'h0BAD);
                progMem[16] = encodeI(cpuPkg::opAddiu, 0, 10, 32'h0BAD);
                progMem[17] = encodeR(8, 7, 10, cpuPkg::fnAddu);
                progMem[18] = encodeJ(32'h48);                          // Spin here
        endtask

        task automatic addRetire(input logic [31:0] pc, input logic wb, input logic [4:0] rg,
                                 input logic [31:0] data, input logic st,
                                 input logic [31:0] sAddr, input logic [31:0] sData,
                                 input int gap);
                expPc[rowCount]     = pc;
                expWb[rowCount]     = wb;
                expReg[rowCount]    = rg;
                expData[rowCount]   = data;
                expStore[rowCount]  = st;
                expAddr[rowCount]   = sAddr;
                expStData[rowCount] = sData;
                expGap[rowCount]    = gap;
                rowCount++;
        endtask

        // Hand-worked retire sequence, gaps in cycles since the previous retire
        task automatic buildExpected();
                addRetire(32'h00, 1'b1, 5'd0,  32'h0000_0007, 1'b0, 32'h0, 32'h0, gapAlu);
                addRetire(32'h04, 1'b1, 5'd1,  32'h0000_0F0F, 1'b0, 32'h0, 32'h0, gapAlu);
                addRetire(32'h08, 1'b1, 5'd2,  32'hFFFF_8001, 1'b0, 32'h0, 32'h0, gapAlu);
                addRetire(32'h0C, 1'b1, 5'd3,  32'hFFFF_8F10, 1'b0, 32'h0, 32'h0, gapAlu);
                addRetire(32'h10, 1'b1, 5'd4,  32'h0000_8F0E, 1'b0, 32'h0, 32'h0, gapAlu);
                addRetire(32'h14, 1'b1, 5'd5,  32'h0000_0001, 1'b0, 32'h0, 32'h0, gapAlu);
                addRetire(32'h18, 1'b1, 5'd6,  32'hFFFF_8F0F, 1'b0, 32'h0, 32'h0, gapAlu);
                addRetire(32'h1C, 1'b1, 5'd7,  32'h0000_0001, 1'b0, 32'h0, 32'h0, gapAlu);
                addRetire(32'h20, 1'b1, 5'd9,  32'h0000_00A0, 1'b0, 32'h0, 32'h0, gapAlu);
                addRetire(32'h24, 1'b0, 5'd0,  32'h0, 1'b1, 32'h90, 32'h0000_8F0E, gapSw);
                addRetire(32'h28, 1'b1, 5'd8,  32'h0000_8F0E, 1'b0, 32'h0, 32'h0, gapLw);
                addRetire(32'h2C, 1'b0, 5'd0,  32'h0, 1'b0, 32'h0, 32'h0, gapAlu);
                addRetire(32'h30, 1'b0, 5'd0,  32'h0, 1'b0, 32'h0, 32'h0, gapAlu);
                addRetire(32'h38, 1'b0, 5'd0,  32'h0, 1'b0, 32'h0, 32'h0, gapAlu);
                addRetire(32'h44, 1'b1, 5'd10, 32'h0000_8F0F, 1'b0, 32'h0, 32'h0, gapAlu);
                addRetire(32'h48, 1'b0, 5'd0,  32'h0, 1'b0, 32'h0, 32'h0, gapAlu);
        endtask

        task automatic checkRetire(input int row);
                int gap;
                gap = cycleCount - lastRetire;
                lastRetire = cycleCount;
                assert (retirePc == expPc[row]) else begin
                        mismatches++;
                        $display("Mismatch at %0t: row %0d retirePc %h, expected %h",
                                 $time, row, retirePc, expPc[row]);
                end
                assert (gap == expGap[row]) else begin
                        mismatches++;
                        $display("Mismatch at %0t: row %0d took %0d cycles, expected %0d",
                                 $time, row, gap, expGap[row]);
                end
                assert (wbValid == expWb[row] && storeValid == expStore[row]) else begin
                        mismatches++;
                        $display("Mismatch at %0t: row %0d wbValid %b storeValid %b",
                                 $time, row, wbValid, storeValid);
                end
                if (expWb[row]) begin
                        assert (wbReg == expReg[row] && wbData == expData[row]) else begin
                                mismatches++;
                                $display("Mismatch at %0t: row %0d wrote r%0d=%h, expected r%0d=%h",
                                         $time, row, wbReg, wbData, expReg[row], expData[row]);
                        end
                end
                if (expStore[row]) begin
                        assert (storeAddr == expAddr[row] && storeData == expStData[row]) else begin
                                mismatches++;
                                $display("Mismatch at %0t: row %0d stored %h at %h, expected %h at %h",
                                         $time, row, storeData, storeAddr,
                                         expStData[row], expAddr[row]);
                        end
                end
        endtask

        task automatic printCounts();
                $display("Summary: %0d mismatches, %0d reset strobe errors, %0d checker failures",
                         mismatches, resetStrobes, cpuTop_inst.cpuTopChk_inst.assertFails);
        endtask

        // No retire or store while the core is held in reset
        always @(negedge Load) begin
                if (rst && cycleCount > 0) begin
                        assert (retire == 1'b0 && storeValid == 1'b0) else begin
                                resetStrobes++;
                                $display("Mismatch at %0t: retire or store strobe during reset",
                                         $time);
                        end
                end
        end

        initial begin
                wait (cycleCount >= cycleLimit);
                $display("Timeout: the core stopped retiring within %0d cycles", cycleLimit);
                printCounts();
                $display("Some tests failed");
                $finish;
        end

        initial begin
                rst       = 1'b1;
                progWrite = 1'b0;
                progAddr  = '0;
                progData  = '0;
                buildProgram();
                buildExpected();
                for (int i = 0; i < progLen; i++) begin
                        @(posedge Load);
                        #1;
                        progWrite = 1'b1;
                        progAddr  = 32'(i * 4);
                        progData  = progMem[i];
                end
                @(posedge Load);
                #1;
                progWrite = 1'b0;
                repeat (resetCycles) @(posedge Load);
                #1;
                rst = 1'b0;
                lastRetire = cycleCount;  // Idle cycle before the first fetch
                for (int row = 0; row < expLen; row++) begin
                        @(negedge Load);
                        while (!retire) @(negedge Load);
                        checkRetire(row);
                end
                printCounts();
                if (mismatches + resetStrobes + cpuTop_inst.cpuTopChk_inst.assertFails == 0) begin
                        $display("All tests passed");
                end else begin
                        $display("Some tests failed");
                end
                $finish;
        end

endmodule

//--- dv/cpuTop_chk.sv
`timescale 1ns/100ps
module cpuTopChk (
        input logic Load,
        input logic rst,
        input logic memStart,
        input logic memDone,
        input logic retire,
        input logic storeValid
);

        logic busy;                 // Access started, done not seen yet
        int   assertFails = 0;

        always_ff @(posedge Load) begin
                if (rst) begin
                        busy <= 1'b0;
                end else if (memDone) begin
                        busy <= 1'b0;
                end else if (memStart) begin
                        busy <= 1'b1;
                end
        end

        storeRetires: assert property (@(posedge Load) disable iff (rst) storeValid |-> retire)
                else begin
                        $error("store strobe without a retire strobe");
                        assertFails++;
                end

        // One memory access in flight at a time
        singleAccess: assert property (@(posedge Load) disable iff (rst) busy |-> !memStart)
                else begin
                        $error("memory start while an access is still open");
                        assertFails++;
                end

        quietReset: assert property (@(posedge Load) rst |=> (!retire && !memStart))
                else begin
                        $error("retire or memory start during reset");
                        assertFails++;
                end

endmodule

//--- logic/cpuTop.sv
`timescale 1ns/100ps
module cpuTop #(
        parameter int memLatency = 3,
        parameter int memWords   = 256
) (
        input  logic                            Load,
        input  logic                            rst,
        input  logic                            progWrite,
        input  logic [cpuPkg::dataWidth-1:0]    progAddr,
        input  logic [cpuPkg::dataWidth-1:0]    progData,
        output logic                            retire,
        output logic [cpuPkg::dataWidth-1:0]    retirePc,
        output logic                            wbValid,
        output logic [cpuPkg::regAddrWidth-1:0] wbReg,
        output logic [cpuPkg::dataWidth-1:0]    wbData,
        output logic                            storeValid,
        output logic [cpuPkg::dataWidth-1:0]    storeAddr,
        output logic [cpuPkg::dataWidth-1:0]    storeData
);

        logic                         memStart, memWrite, memDone;
        logic [cpuPkg::dataWidth-1:0] memAddr, memWdata, memRdata;
        logic                         irLoad, pcLoad, marLoad, mdrLoad, regWrite;
        logic                         aluSrcImm, marFromPc, wbFromMem, wbDestRt;
        logic                         pcFromJump, branchTaken, aluZero;
        logic [5:0]                   opcode, funct;
        cpuPkg::aluOp                 aluSel;

        cpuControl cpuControl_inst (
                .Load (Load), .rst (rst), .memDone (memDone),
                .opcode (opcode), .funct (funct), .aluZero (aluZero),
                .memStart (memStart), .memWrite (memWrite),
                .irLoad (irLoad), .pcLoad (pcLoad), .marLoad (marLoad),
                .mdrLoad (mdrLoad), .regWrite (regWrite), .aluSel (aluSel),
                .aluSrcImm (aluSrcImm), .marFromPc (marFromPc),
                .wbFromMem (wbFromMem), .wbDestRt (wbDestRt),
                .pcFromJump (pcFromJump), .branchTaken (branchTaken),
                .retire (retire)
        );

        accessTimer #(.memLatency (memLatency)) accessTimer_inst (
                .Load (Load), .rst (rst), .memStart (memStart), .memDone (memDone)
        );

        wordMemory #(.memWords (memWords)) wordMemory_inst (
                .Load (Load), .rst (rst),
                .progWrite (progWrite), .progAddr (progAddr), .progData (progData),
                .memStart (memStart), .memWrite (memWrite), .memDone (memDone),
                .memAddr (memAddr), .memWdata (memWdata), .memRdata (memRdata)
        );

        cpuDatapath cpuDatapath_inst (
                .Load (Load), .rst (rst),
                .irLoad (irLoad), .pcLoad (pcLoad), .marLoad (marLoad),
                .mdrLoad (mdrLoad), .regWrite (regWrite), .aluSel (aluSel),
                .aluSrcImm (aluSrcImm), .marFromPc (marFromPc),
                .wbFromMem (wbFromMem), .wbDestRt (wbDestRt),
                .pcFromJump (pcFromJump), .branchTaken (branchTaken),
                .memWrite (memWrite), .memDone (memDone), .memRdata (memRdata),
                .opcode (opcode), .funct (funct), .aluZero (aluZero),
                .memAddr (memAddr), .memWdata (memWdata), .retirePc (retirePc),
                .wbReg (wbReg), .wbData (wbData), .wbValid (wbValid),
                .storeAddr (storeAddr), .storeData (storeData),
                .storeValid (storeValid)
        );

endmodule

//--- logic/cpuDatapath.sv
`timescale 1ns/100ps
module cpuDatapath (
        input  logic                            Load,
        input  logic                            rst,
        input  logic                            irLoad,
        input  logic                            pcLoad,
        input  logic                            marLoad,
        input  logic                            mdrLoad,
        input  logic                            regWrite,
        input  cpuPkg::aluOp                    aluSel,
        input  logic                            aluSrcImm,
        input  logic                            marFromPc,
        input  logic                            wbFromMem,
        input  logic                            wbDestRt,
        input  logic                            pcFromJump,
        input  logic                            branchTaken,
        input  logic                            memWrite,
        input  logic                            memDone,
        input  logic [cpuPkg::dataWidth-1:0]    memRdata,
        output logic [5:0]                      opcode,
        output logic [5:0]                      funct,
        output logic                            aluZero,
        output logic [cpuPkg::dataWidth-1:0]    memAddr,
        output logic [cpuPkg::dataWidth-1:0]    memWdata,
        output logic [cpuPkg::dataWidth-1:0]    retirePc,
        output logic [cpuPkg::regAddrWidth-1:0] wbReg,
        output logic [cpuPkg::dataWidth-1:0]    wbData,
        output logic                            wbValid,
        output logic [cpuPkg::dataWidth-1:0]    storeAddr,
        output logic [cpuPkg::dataWidth-1:0]    storeData,
        output logic                            storeValid
);

        logic [cpuPkg::dataWidth-1:0]    pc, ir, mar, mdr, opA, opB, aluOut;
        logic [cpuPkg::dataWidth-1:0]    rdDataA, rdDataB, aluB, aluResult;
        logic [cpuPkg::dataWidth-1:0]    signExt, pcPlus4, pcNext;
        logic [cpuPkg::regAddrWidth-1:0] destReg;

        assign opcode  = ir[31:26];
        assign funct   = ir[5:0];
        assign signExt = {{16{ir[15]}}, ir[15:0]};
        assign pcPlus4 = pc + 32'd4;
        assign aluB    = aluSrcImm ? signExt : opB;
        assign destReg = wbDestRt ? ir[20:16] : ir[15:11];  // rt for I-type, rd for R-type
        assign wbData  = wbFromMem ? mdr : aluOut;

        always_comb begin
                if (pcFromJump) begin
                        pcNext = {pcPlus4[31:28], ir[25:0], 2'b00};
                end else if (branchTaken) begin
                        pcNext = pcPlus4 + {signExt[29:0], 2'b00};
                end else begin
                        pcNext = pcPlus4;
                end
        end

        always_ff @(posedge Load) begin
                if (rst) begin
                        pc  <= '0;
                        mar <= '0;  // First fetch address
                end else begin
                        if (pcLoad) begin
                                pc <= pcNext;
                        end
                        if (marLoad) begin
                                mar <= marFromPc ? pcNext : aluResult;
                        end
                end
        end

        // Operand and result registers track every cycle
        always_ff @(posedge Load) begin
                opA    <= rdDataA;
                opB    <= rdDataB;
                aluOut <= aluResult;
                if (irLoad) begin
                        ir <= memRdata;
                end
                if (mdrLoad) begin
                        mdr <= wbFromMem ? memRdata : opB;  // Load data or store data
                end
        end

        regFile regFile_inst (
                .Load     (Load),
                .rst      (rst),
                .rdAddrA  (ir[25:21]),
                .rdAddrB  (ir[20:16]),
                .wrEnable (regWrite),
                .wrAddr   (destReg),
                .wrData   (wbData),
                .rdDataA  (rdDataA),
                .rdDataB  (rdDataB)
        );

        aluUnit aluUnit_inst (
                .opA    (opA),
                .opB    (aluB),
                .aluSel (aluSel),
                .result (aluResult),
                .zero   (aluZero)
        );

        assign memAddr    = mar;
        assign memWdata   = mdr;
        assign retirePc   = pc;
        assign wbReg      = destReg;
        assign wbValid    = regWrite;
        assign storeValid = memWrite && memDone;
        assign storeAddr  = mar;
        assign storeData  = mdr;

endmodule

//--- logic/cpuControl.sv
`timescale 1ns/100ps
module cpuControl (
        input  logic         Load,
        input  logic         rst,
        input  logic         memDone,
        input  logic [5:0]   opcode,
        input  logic [5:0]   funct,
        input  logic         aluZero,
        output logic         memStart,
        output logic         memWrite,
        output logic         irLoad,
        output logic         pcLoad,
        output logic         marLoad,
        output logic         mdrLoad,
        output logic         regWrite,
        output cpuPkg::aluOp aluSel,
        output logic         aluSrcImm,
        output logic         marFromPc,
        output logic         wbFromMem,
        output logic         wbDestRt,
        output logic         pcFromJump,
        output logic         branchTaken,
        output logic         retire
);

        cpuPkg::cpuState state;
        cpuPkg::cpuState nextState;
        logic            pending;   // Access issued, done not yet seen
        logic            inMem;

        always_ff @(posedge Load) begin
                if (rst) begin
                        state   <= cpuPkg::stIdle;
                        pending <= 1'b0;
                end else begin
                        state <= nextState;
                        if (memDone) begin
                                pending <= 1'b0;
                        end else if (memStart) begin
                                pending <= 1'b1;
                        end
                end
        end

        always_comb begin
                nextState = state;
                case (state)
                        cpuPkg::stIdle:      nextState = cpuPkg::stFetch;
                        cpuPkg::stFetch:     nextState = cpuPkg::stFetchWait;
                        cpuPkg::stFetchWait: if (memDone) nextState = cpuPkg::stDecode;
                        cpuPkg::stDecode: begin
                                case (opcode)
                                        cpuPkg::opRType: nextState = cpuPkg::stExecR;
                                        cpuPkg::opAddiu: nextState = cpuPkg::stExecI;
                                        cpuPkg::opLw,
                                        cpuPkg::opSw:    nextState = cpuPkg::stAddrCalc;
                                        default:         nextState = cpuPkg::stExecR;  // BEQ, J, unknown
                                endcase
                        end
                        cpuPkg::stExecR: begin
                                if (opcode == cpuPkg::opRType) begin
                                        nextState = cpuPkg::stWriteBack;
                                end else if (opcode == cpuPkg::opJ) begin
                                        nextState = cpuPkg::stJump;
                                end else begin
                                        nextState = cpuPkg::stBranch;  // Unknown ops fall through as no-ops
                                end
                        end
                        cpuPkg::stExecI:    nextState = cpuPkg::stWriteBack;
                        cpuPkg::stAddrCalc: begin
                                nextState = (opcode == cpuPkg::opLw) ? cpuPkg::stMemRead
                                                                     : cpuPkg::stMemWrite;
                        end
                        cpuPkg::stMemRead:  if (memDone) nextState = cpuPkg::stWriteBack;
                        cpuPkg::stMemWrite: if (memDone) nextState = cpuPkg::stFetch;
                        default:            nextState = cpuPkg::stFetch;  // Writeback, branch, jump
                endcase
        end

        // ALU operation depends only on the instruction
        always_comb begin
                aluSel = cpuPkg::aluAdd;
                if (opcode == cpuPkg::opBeq) begin
                        aluSel = cpuPkg::aluSub;
                end else if (opcode == cpuPkg::opRType) begin
                        case (funct)
                                cpuPkg::fnSubu: aluSel = cpuPkg::aluSub;
                                cpuPkg::fnAnd:  aluSel = cpuPkg::aluAnd;
                                cpuPkg::fnOr:   aluSel = cpuPkg::aluOr;
                                cpuPkg::fnSlt:  aluSel = cpuPkg::aluSlt;
                                default:        aluSel = cpuPkg::aluAdd;
                        endcase
                end
        end

        assign inMem     = (state == cpuPkg::stMemRead) || (state == cpuPkg::stMemWrite);
        assign memStart  = (state == cpuPkg::stFetch) || (inMem && !pending);
        assign memWrite  = (state == cpuPkg::stMemWrite);
        assign irLoad    = (state == cpuPkg::stFetchWait) && memDone;
        assign retire    = (state == cpuPkg::stWriteBack) || (state == cpuPkg::stBranch) ||
                           (state == cpuPkg::stJump) || (memWrite && memDone);
        assign pcLoad    = retire;
        assign marFromPc = retire;  // MAR follows the PC for the next fetch
        assign marLoad   = retire || (state == cpuPkg::stAddrCalc);
        assign mdrLoad   = (state == cpuPkg::stAddrCalc) ||
                           ((state == cpuPkg::stMemRead) && memDone);
        assign regWrite  = (state == cpuPkg::stWriteBack);
        assign aluSrcImm = (state == cpuPkg::stExecI) || (state == cpuPkg::stAddrCalc);
        assign wbFromMem = (opcode == cpuPkg::opLw);
        assign wbDestRt  = (opcode != cpuPkg::opRType);
        assign pcFromJump  = (state == cpuPkg::stJump);
        assign branchTaken = (state == cpuPkg::stBranch) && (opcode == cpuPkg::opBeq) && aluZero;

endmodule

//--- logic/wordMemory.sv
`timescale 1ns/100ps
module wordMemory #(
        parameter int memWords = 256
) (
        input  logic                          Load,
        input  logic                          rst,
        input  logic                          progWrite,
        input  logic [cpuPkg::dataWidth-1:0]  progAddr,
        input  logic [cpuPkg::dataWidth-1:0]  progData,
        input  logic                          memStart,
        input  logic                          memWrite,
        input  logic                          memDone,
        input  logic [cpuPkg::dataWidth-1:0]  memAddr,
        input  logic [cpuPkg::dataWidth-1:0]  memWdata,
        output logic [cpuPkg::dataWidth-1:0]  memRdata
);

        localparam int addrWidth = $clog2(memWords);

        logic [cpuPkg::dataWidth-1:0] mem [memWords];
        logic [addrWidth-1:0]         reqIdx;   // Word index of the open request
        logic [cpuPkg::dataWidth-1:0] reqData;
        logic                         reqWrite;

        always_ff @(posedge Load) begin
                if (rst) begin
                        reqWrite <= 1'b0;
                end else if (memStart) begin
                        reqWrite <= memWrite;
                end
        end

        always_ff @(posedge Load) begin
                if (memStart) begin
                        reqIdx  <= memAddr[addrWidth+1:2];
                        reqData <= memWdata;
                end
                if (rst && progWrite) begin
                        mem[progAddr[addrWidth+1:2]] <= progData;  // Program load
                end else if (memDone && reqWrite) begin
                        mem[reqIdx] <= reqData;
                end
        end

        assign memRdata = mem[reqIdx];  // Sampled by the core on memDone

endmodule

//--- logic/accessTimer.sv
`timescale 1ns/100ps
module accessTimer #(
        parameter int memLatency = 3
) (
        input  logic Load,
        input  logic rst,
        input  logic memStart,
        output logic memDone
);

        localparam int cntWidth = $clog2(memLatency + 1);

        logic [cntWidth-1:0] count;   // Zero when idle

        always_ff @(posedge Load) begin
                if (rst) begin
                        count <= '0;
                end else if (count != '0) begin
                        count <= count - 1'b1;  // Starts while busy are dropped
                end else if (memStart) begin
                        count <= cntWidth'(memLatency);
                end
        end

        assign memDone = (count == cntWidth'(1));

endmodule

//--- logic/regFile.sv
`timescale 1ns/100ps
module regFile (
        input  logic                            Load,
        input  logic                            rst,
        input  logic [cpuPkg::regAddrWidth-1:0] rdAddrA,
        input  logic [cpuPkg::regAddrWidth-1:0] rdAddrB,
        input  logic                            wrEnable,
        input  logic [cpuPkg::regAddrWidth-1:0] wrAddr,
        input  logic [cpuPkg::dataWidth-1:0]    wrData,
        output logic [cpuPkg::dataWidth-1:0]    rdDataA,
        output logic [cpuPkg::dataWidth-1:0]    rdDataB
);

        logic [cpuPkg::dataWidth-1:0] regs [2**cpuPkg::regAddrWidth];

        always_ff @(posedge Load) begin
                if (rst) begin
                        for (int i = 0; i < 2**cpuPkg::regAddrWidth; i++) begin
                                regs[i] <= '0;
                        end
                end else if (wrEnable && (wrAddr != '0)) begin
                        regs[wrAddr] <= wrData;  // $zero never changes
                end
        end

        assign rdDataA = regs[rdAddrA];
        assign rdDataB = regs[rdAddrB];

endmodule

//--- logic/aluUnit.sv
`timescale 1ns/100ps
module aluUnit (
        input  logic [cpuPkg::dataWidth-1:0] opA,
        input  logic [cpuPkg::dataWidth-1:0] opB,
        input  cpuPkg::aluOp                 aluSel,
        output logic [cpuPkg::dataWidth-1:0] result,
        output logic                         zero
);

        always_comb begin
                case (aluSel)
                        cpuPkg::aluSub: result = opA - opB;
                        cpuPkg::aluAnd: result = opA & opB;
                        cpuPkg::aluOr:  result = opA | opB;
                        cpuPkg::aluSlt: begin
                                result = {{(cpuPkg::dataWidth-1){1'b0}},
                                          ($signed(opA) < $signed(opB))};
                        end
                        default:        result = opA + opB;  // No overflow trap
                endcase
        end

        assign zero = (result == '0);  // Equality test for BEQ

endmodule

//--- logic/cpuPkg.sv
package cpuPkg;

        parameter int dataWidth    = 32;
        parameter int regAddrWidth = 5;

        // Primary opcodes
        parameter logic [5:0] opRType = 6'h00;
        parameter logic [5:0] opJ     = 6'h02;
        parameter logic [5:0] opBeq   = 6'h04;
        parameter logic [5:0] opAddiu = 6'h09;
        parameter logic [5:0] opLw    = 6'h23;
        parameter logic [5:0] opSw    = 6'h2b;

        // R-type function field
        parameter logic [5:0] fnAddu = 6'h21;
        parameter logic [5:0] fnSubu = 6'h23;
        parameter logic [5:0] fnAnd  = 6'h24;
        parameter logic [5:0] fnOr   = 6'h25;
        parameter logic [5:0] fnSlt  = 6'h2a;

        typedef enum logic [2:0] {
                aluAdd,
                aluSub,
                aluAnd,
                aluOr,
                aluSlt
        } aluOp;

        typedef enum logic [3:0] {
                stIdle, stFetch, stFetchWait, stDecode,
                stExecR, stExecI, stAddrCalc,
                stMemRead, stMemWrite, stWriteBack,
                stBranch, stJump
        } cpuState;

endpackage
